//--- compile.f
+incdir+hdl
hdl/ahb_bus_pkg.sv
hdl/ahb_mtx_pkg.sv
hdl/ahb_mtx_arbiter.sv
hdl/ahb_mtx_addr_mux.sv
hdl/ahb_mtx_data_phase.sv
hdl/ahb_mtx_output_stage.sv
tb/tb_output_stage.sv

//--- hdl/ahb_bus_pkg.sv
// AHB protocol types
`include "ahb_mtx_settings.svh"

package ahb_bus_pkg;

  // Transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Burst pause
    NONSEQ = 2'b10,  // First beat
    SEQ    = 2'b11   // Following beats
  } htrans_e;

  // Arbitration only tells SINGLE from the rest
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // One 51-bit address phase
  typedef struct packed {
    logic                   sel;       // HSEL
    logic [`AHB_ADDR_W-1:0] addr;      // HADDR
    htrans_e                trans;     // HTRANS
    logic                   write;     // HWRITE
    logic [2:0]             size;      // HSIZE
    hburst_e                burst;     // HBURST
    logic [3:0]             prot;      // HPROT
    logic [3:0]             master;    // HMASTER
    logic                   mastlock;  // HMASTLOCK
  } ahb_addr_ctrl_t;

endpackage

//--- hdl/ahb_mtx_addr_mux.sv
// Address phase mux and active decode
`timescale 1ns/1ps
`include "ahb_mtx_settings.svh"

module ahb_mtx_addr_mux
  import ahb_bus_pkg::*, ahb_mtx_pkg::*;
(
  input  port_idx_t      i_grant,                       // Granted port
  input  ahb_addr_ctrl_t i_addr_ctrl [`MTX_NUM_PORTS],  // Per-port address phase
  output ahb_addr_ctrl_t o_sel_ctrl,                    // Routed address phase
  output port_vec_t      o_active                       // One-hot active port
);

  // --------------------------------------
  // Address routing
  // --------------------------------------
  // Zero when no port owns the slave
  always_comb
  begin
    o_sel_ctrl = '0;
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
    begin
      if (i_grant == port_idx_t'(p + 1))
        o_sel_ctrl = i_addr_ctrl[p];  // Array slot 0 is port 1
    end
  end

  // --------------------------------------
  // Active flags
  // --------------------------------------
  always_comb
  begin
    o_active = '0;
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
    begin
      if (i_grant == port_idx_t'(p + 1))
        o_active[p] = 1'b1;
    end
  end

endmodule

//--- hdl/ahb_mtx_arbiter.sv
// Output stage round-robin arbiter
`timescale 1ns/1ps
`include "ahb_mtx_settings.svh"

module ahb_mtx_arbiter
  import ahb_bus_pkg::*, ahb_mtx_pkg::*;
(
  input  logic           i_hclk,       // AHB clock
  input  logic           HRESETn,      // Sync reset, active low
  input  port_vec_t      i_req,        // Port requests
  input  ahb_addr_ctrl_t i_sel_ctrl,   // Address phase of granted port
  input  logic           i_hreadymux,  // Slave side HREADY
  output port_idx_t      o_grant       // Granted port
);

  port_idx_t grant_r;    // Current grant
  port_idx_t grant_nxt;  // Grant for next accepted cycle
  port_idx_t last_ptr;   // Last nonzero grant
  port_idx_t rr_grant;   // Round-robin choice
  logic      lock_flg;   // Locked sequence started here
  logic      lock_nxt;
  logic      lock_held;  // Keep grant for lock
  logic      cur_req;    // Granted port still requests
  logic      burst_hold; // Keep grant for burst

  // --------------------------------------
  // Hold conditions
  // --------------------------------------
  // Lock survives HSEL dropping once sequence has begun
  assign lock_held = i_sel_ctrl.mastlock & (i_sel_ctrl.sel | lock_flg);

  assign cur_req = (grant_r != NO_PORT) ? i_req[grant_r - 1'b1] : 1'b0;

  // Any non-SINGLE burst is treated as INCR
  assign burst_hold = cur_req
                    & (i_sel_ctrl.trans != IDLE)
                    & (i_sel_ctrl.burst != SINGLE);

  // Set on locked NONSEQ/SEQ, clear when lock drops
  assign lock_nxt = (i_sel_ctrl.sel
                     && (i_sel_ctrl.trans == NONSEQ || i_sel_ctrl.trans == SEQ)
                     && i_sel_ctrl.mastlock) ? 1'b1 :
                    (!i_sel_ctrl.mastlock)   ? 1'b0 :
                                               lock_flg;

  // --------------------------------------
  // Round robin
  // --------------------------------------
  always_comb
  begin
    int cand;  // Candidate port number
    rr_grant = NO_PORT;
    // Walk backwards so the nearest port after last_ptr wins
    for (int k = `MTX_NUM_PORTS; k >= 1; k--)
    begin
      cand = ((int'(last_ptr) - 1 + k) % `MTX_NUM_PORTS) + 1;
      if (i_req[cand-1])
        rr_grant = port_idx_t'(cand);
    end
  end

  always_comb
  begin
    grant_nxt = rr_grant;
    if (lock_held || burst_hold)
      grant_nxt = grant_r;  // Hold current owner
  end

  // State only moves on accepted cycles
  always_ff @(posedge i_hclk)
  begin
    if (!HRESETn)
    begin
      grant_r  <= NO_PORT;
      last_ptr <= port_idx_t'(`MTX_NUM_PORTS);  // Port 1 wins first
      lock_flg <= 1'b0;
    end
    else if (i_hreadymux)
    begin
      grant_r  <= grant_nxt;
      lock_flg <= lock_nxt;
      if (grant_nxt != NO_PORT)
        last_ptr <= grant_nxt;
    end
  end

  assign o_grant = grant_r;

endmodule

//--- hdl/ahb_mtx_data_phase.sv
// Data phase routing and HREADYMUXM
`timescale 1ns/1ps
`include "ahb_mtx_settings.svh"

module ahb_mtx_data_phase
  import ahb_bus_pkg::*, ahb_mtx_pkg::*;
(
  input  logic                   i_hclk,                   // AHB clock
  input  logic                   HRESETn,                  // Sync reset, active low
  input  port_idx_t              i_grant,                  // Address phase owner
  input  ahb_addr_ctrl_t         i_sel_ctrl,               // Routed address phase
  input  logic [`AHB_DATA_W-1:0] i_wdata [`MTX_NUM_PORTS], // Per-port write data
  input  logic                   i_hreadyout,              // Slave HREADYOUT
  output logic [`AHB_DATA_W-1:0] o_hwdata,                 // Routed write data
  output logic                   o_hreadymux               // HREADYMUXM
);

  port_idx_t data_port;  // Data phase owner
  logic      slave_sel;  // Slave selected in data phase
  logic      hreadymux;

  // --------------------------------------
  // Data phase registers
  // --------------------------------------
  // Address phase becomes data phase on each accepted cycle
  always_ff @(posedge i_hclk)
  begin
    if (!HRESETn)
    begin
      data_port <= NO_PORT;
      slave_sel <= 1'b0;
    end
    else if (hreadymux)
    begin
      data_port <= i_grant;
      slave_sel <= i_sel_ctrl.sel;
    end
  end

  // Write data mux with zero for no port
  always_comb
  begin
    o_hwdata = '0;
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
    begin
      if (data_port == port_idx_t'(p + 1))
        o_hwdata = i_wdata[p];
    end
  end

  // Slave only stalls when it owns the data phase
  assign hreadymux   = slave_sel ? i_hreadyout : 1'b1;
  assign o_hreadymux = hreadymux;

endmodule

//--- hdl/ahb_mtx_output_stage.sv
// AHB matrix shared slave output stage
`timescale 1ns/1ps
`include "ahb_mtx_settings.svh"

module ahb_mtx_output_stage
  import ahb_bus_pkg::*, ahb_mtx_pkg::*;
(
  input  logic                   i_hclk,                       // AHB clock
  input  logic                   HRESETn,                      // Sync reset, active low
  input  ahb_addr_ctrl_t         i_addr_ctrl [`MTX_NUM_PORTS], // Port address phases
  input  logic [`AHB_DATA_W-1:0] i_wdata [`MTX_NUM_PORTS],     // Port write data
  input  port_vec_t              i_held_tran,                  // Port holds a transfer
  input  logic                   i_hreadyout,                  // Slave HREADYOUT
  output port_vec_t              o_active,                     // Active port flags
  output ahb_addr_ctrl_t         o_addr_ctrl,                  // Slave address phase
  output logic [`AHB_DATA_W-1:0] o_hwdata,                     // Slave HWDATA
  output logic                   o_hreadymux                   // HREADYMUXM
);

  port_vec_t req;    // Port requests
  port_idx_t grant;  // Address phase owner

  // --------------------------------------
  // Requests
  // --------------------------------------
  // Held transfer aimed at this slave
  always_comb
  begin
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
      req[p] = i_held_tran[p] & i_addr_ctrl[p].sel;
  end

  // --------------------------------------
  // Stages
  // --------------------------------------
  ahb_mtx_arbiter u_arbiter (
    .i_hclk      (i_hclk),
    .HRESETn     (HRESETn),
    .i_req       (req),
    .i_sel_ctrl  (o_addr_ctrl),  // Fed back for hold rules
    .i_hreadymux (o_hreadymux),
    .o_grant     (grant)
  );

  ahb_mtx_addr_mux u_addr_mux (
    .i_grant     (grant),
    .i_addr_ctrl (i_addr_ctrl),
    .o_sel_ctrl  (o_addr_ctrl),
    .o_active    (o_active)
  );

  ahb_mtx_data_phase u_data_phase (
    .i_hclk      (i_hclk),
    .HRESETn     (HRESETn),
    .i_grant     (grant),
    .i_sel_ctrl  (o_addr_ctrl),
    .i_wdata     (i_wdata),
    .i_hreadyout (i_hreadyout),
    .o_hwdata    (o_hwdata),
    .o_hreadymux (o_hreadymux)
  );

endmodule

//--- hdl/ahb_mtx_pkg.sv
// Bus matrix port types
`include "ahb_mtx_settings.svh"

package ahb_mtx_pkg;

  // --------------------------------------
  // Port index
  // --------------------------------------
  // 0 is no port, 1 to 3 name input ports 1 to 3
  typedef logic [`MTX_PORT_IDX_W-1:0] port_idx_t;

  // --------------------------------------
  // Port flags
  // --------------------------------------
  // Bit 0 is port 1
  typedef logic [`MTX_NUM_PORTS-1:0] port_vec_t;

  // Idle index
  localparam port_idx_t NO_PORT = '0;

endpackage

//--- hdl/ahb_mtx_settings.svh
// AHB matrix bus settings
`ifndef AHB_MTX_SETTINGS_SVH
`define AHB_MTX_SETTINGS_SVH

// --------------------------------------
// Bus widths
// --------------------------------------
`define AHB_ADDR_W 32      // HADDR width
`define AHB_DATA_W 32      // HWDATA width

// --------------------------------------
// Matrix ports
// --------------------------------------
`define MTX_NUM_PORTS 3    // Input ports sharing this slave
`define MTX_PORT_IDX_W 2   // Index width with 0 reserved for no port

`endif

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
rm -rf obj_dir sim.log
verilator --binary --timing -f compile.f --top-module tb_output_stage -o tb_output_stage \
  && ./obj_dir/tb_output_stage 2>&1 | tee sim.log
grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb/tb_output_stage.sv
// Output stage testbench
`timescale 1ns/1ps
`include "ahb_mtx_settings.svh"

module tb_output_stage
  import ahb_bus_pkg::*, ahb_mtx_pkg::*;
;

  localparam int MAX_CYCLES = 2000;  // Far above the length of all tests

  logic                   clk;
  logic                   HRESETn;
  ahb_addr_ctrl_t         addr_ctrl [`MTX_NUM_PORTS];  // Port address phases
  logic [`AHB_DATA_W-1:0] wdata [`MTX_NUM_PORTS];      // Port write data
  port_vec_t              held_tran;
  logic                   hreadyout;
  port_vec_t              active;
  ahb_addr_ctrl_t         addr_out;
  logic [`AHB_DATA_W-1:0] hwdata;
  logic                   hreadymux;

  logic [31:0] rng_state;   // Xorshift state
  int          cycle_count;
  port_idx_t   m_grant;     // Model grant
  port_idx_t   m_last;      // Model last-granted pointer
  logic        m_lock;      // Model lock flag
  port_idx_t   m_dport;     // Model data phase port
  logic        m_ssel;      // Model slave selected flag

  ahb_mtx_output_stage dut_i (
    .i_hclk      (clk),
    .HRESETn     (HRESETn),
    .i_addr_ctrl (addr_ctrl),
    .i_wdata     (wdata),
    .i_held_tran (held_tran),
    .i_hreadyout (hreadyout),
    .o_active    (active),
    .o_addr_ctrl (addr_out),
    .o_hwdata    (hwdata),
    .o_hreadymux (hreadymux)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // Hang guard
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: the run hung and did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "Simulation stopped by cycle limit");
    end
  end

  // --------------------------------------
  // Stimulus helpers
  // --------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // New address phase and write data on port p
  task automatic set_port(input int p, input logic req, input htrans_e trans,
                          input hburst_e burst, input logic lock);
    logic [31:0] r;
    r = next_rand();
    addr_ctrl[p-1].sel      = req;
    addr_ctrl[p-1].addr     = next_rand();
    addr_ctrl[p-1].trans    = trans;
    addr_ctrl[p-1].write    = r[0];
    addr_ctrl[p-1].size     = 3'd2;  // Word
    addr_ctrl[p-1].burst    = burst;
    addr_ctrl[p-1].prot     = r[7:4];
    addr_ctrl[p-1].master   = 4'(p);
    addr_ctrl[p-1].mastlock = lock;
    wdata[p-1]              = next_rand();
    held_tran[p-1]          = req;
  endtask

  // Request gone while mastlock and write data stay
  task automatic drop_port(input int p);
    held_tran[p-1]       = 1'b0;
    addr_ctrl[p-1].sel   = 1'b0;
    addr_ctrl[p-1].trans = IDLE;
  endtask

  task automatic idle_inputs();
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
      addr_ctrl[p] = '0;
    held_tran = '0;
    hreadyout = 1'b1;
  endtask

  // --------------------------------------
  // Reference model
  // --------------------------------------
  function automatic ahb_addr_ctrl_t model_sel();
    if (m_grant == NO_PORT)
      return '0;
    return addr_ctrl[int'(m_grant)-1];
  endfunction

  function automatic logic model_ready();
    return m_ssel ? hreadyout : 1'b1;  // Unselected slave never stalls
  endfunction

  function automatic port_vec_t model_active();
    port_vec_t v;
    v = '0;
    if (m_grant != NO_PORT)
      v[int'(m_grant)-1] = 1'b1;
    return v;
  endfunction

  function automatic logic [`AHB_DATA_W-1:0] model_hwdata();
    if (m_dport == NO_PORT)
      return '0;
    return wdata[int'(m_dport)-1];
  endfunction

  // Clock edge as seen by the arbitration rules
  task automatic update_model();
    ahb_addr_ctrl_t s;
    port_vec_t      req;
    port_idx_t      nxt;
    logic           hold;
    int             cand;
    s = model_sel();
    if (model_ready())
    begin
      for (int p = 0; p < `MTX_NUM_PORTS; p++)
        req[p] = held_tran[p] & addr_ctrl[p].sel;
      hold = s.mastlock && (s.sel || m_lock);  // Lock keeps owner
      if (m_grant != NO_PORT)
      begin
        if (req[int'(m_grant)-1] && s.trans != IDLE && s.burst != SINGLE)
          hold = 1'b1;  // Burst keeps owner
      end
      nxt = NO_PORT;
      if (hold)
        nxt = m_grant;
      else
      begin
        // First requester after the pointer in order 1 2 3 1
        for (int i = 1; i <= `MTX_NUM_PORTS; i++)
        begin
          cand = ((int'(m_last) + i - 1) % `MTX_NUM_PORTS) + 1;
          if (nxt == NO_PORT && req[cand-1])
            nxt = port_idx_t'(cand);
        end
      end
      if (s.sel && (s.trans == NONSEQ || s.trans == SEQ) && s.mastlock)
        m_lock = 1'b1;
      else if (!s.mastlock)
        m_lock = 1'b0;
      m_dport = m_grant;
      m_ssel  = s.sel;
      m_grant = nxt;
      if (nxt != NO_PORT)
        m_last = nxt;
    end
  endtask

  // Edge, model step, then the drive point
  task automatic next_cycle();
    @(posedge clk);
    update_model();
    #1;
  endtask

  // --------------------------------------
  // Compare tasks
  // --------------------------------------
  task automatic fail_run(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "Stopped at first mismatch");
  endtask

  task automatic check_addr_ctrl(input ahb_addr_ctrl_t act, input ahb_addr_ctrl_t exp,
                                 input string what);
    if (act !== exp)
      fail_run($sformatf("%s: o_addr_ctrl %h, expected %h", what, act, exp));
  endtask

  task automatic check_ports(input port_vec_t act, input port_vec_t exp, input string what);
    if (act !== exp)
      fail_run($sformatf("%s: o_active %b, expected %b", what, act, exp));
  endtask

  task automatic check_word(input logic [`AHB_DATA_W-1:0] act,
                            input logic [`AHB_DATA_W-1:0] exp, input string what);
    if (act !== exp)
      fail_run($sformatf("%s: o_hwdata %h, expected %h", what, act, exp));
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp)
      fail_run($sformatf("%s: o_hreadymux %b, expected %b", what, act, exp));
  endtask

  // Settle, then compare everything against the model
  task automatic check_all();
    #1;
    check_ports(active, model_active(), "model active");
    check_addr_ctrl(addr_out, model_sel(), "model address phase");
    check_word(hwdata, model_hwdata(), "model write data");
    check_flag(hreadymux, model_ready(), "model ready");
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      next_cycle();
      idle_inputs();
      check_all();
    end
  endtask

  // --------------------------------------
  // Directed tests
  // --------------------------------------
  task automatic test_reset();
    check_all();
    check_ports(active, '0, "reset active");
    check_addr_ctrl(addr_out, '0, "reset address phase");
    check_word(hwdata, '0, "reset write data");
    check_flag(hreadymux, 1'b1, "reset ready");
  endtask

  task automatic test_single();
    ahb_addr_ctrl_t         ac;
    logic [`AHB_DATA_W-1:0] wd;
    next_cycle();
    set_port(2, 1'b1, NONSEQ, SINGLE, 1'b0);
    addr_ctrl[1].write = 1'b1;  // Write transfer
    ac = addr_ctrl[1];
    wd = wdata[1];
    check_all();
    next_cycle();
    check_all();
    check_ports(active, 3'b010, "single grant");
    check_addr_ctrl(addr_out, ac, "single address phase");
    next_cycle();
    drop_port(2);
    check_all();
    check_word(hwdata, wd, "single write data");
  endtask

  task automatic test_round_robin();
    int g0;  // First port granted
    for (int k = 0; k < 12; k++)
    begin
      next_cycle();
      if (k == 1)
        g0 = int'(m_grant);
      for (int p = 1; p <= `MTX_NUM_PORTS; p++)
        set_port(p, 1'b1, NONSEQ, SINGLE, 1'b0);
      check_all();
      if (k >= 1)
        check_ports(active, 3'b001 << ((g0 - 1 + k - 1) % 3), "round robin order");
    end
  endtask

  task automatic test_burst_hold();
    next_cycle();
    set_port(1, 1'b1, NONSEQ, INCR, 1'b0);
    check_all();
    next_cycle();
    set_port(3, 1'b1, NONSEQ, SINGLE, 1'b0);  // Competing request
    check_all();
    check_ports(active, 3'b001, "burst first beat");
    for (int b = 0; b < 3; b++)
    begin
      next_cycle();
      set_port(1, 1'b1, SEQ, INCR, 1'b0);
      check_all();
      check_ports(active, 3'b001, "burst beat");
    end
    next_cycle();
    drop_port(1);
    check_all();
    check_ports(active, 3'b001, "burst ends");
    next_cycle();
    check_all();
    check_ports(active, 3'b100, "burst handover");
  endtask

  task automatic test_locked();
    next_cycle();
    set_port(2, 1'b1, NONSEQ, SINGLE, 1'b1);
    check_all();
    next_cycle();
    set_port(1, 1'b1, NONSEQ, SINGLE, 1'b0);
    set_port(3, 1'b1, NONSEQ, SINGLE, 1'b0);
    check_all();
    check_ports(active, 3'b010, "locked grant");
    repeat (3)
    begin
      next_cycle();
      drop_port(2);  // HSEL low, mastlock still high
      check_all();
      check_ports(active, 3'b010, "lock held without sel");
    end
    next_cycle();
    addr_ctrl[1].mastlock = 1'b0;
    check_all();
    check_ports(active, 3'b010, "lock release");
    next_cycle();
    check_all();
    check_ports(active, 3'b100, "round robin after lock");
    next_cycle();
    check_all();
    check_ports(active, 3'b001, "round robin continues");
  endtask

  task automatic test_wait_states();
    int                     n;   // Wait cycles
    logic [`AHB_DATA_W-1:0] wd;
    n = int'(next_rand() % 32'd4) + 1;
    next_cycle();
    set_port(1, 1'b1, NONSEQ, SINGLE, 1'b0);
    check_all();
    next_cycle();
    held_tran[0] = 1'b0;  // Address phase stays on the bus without a new request
    wd = wdata[0];
    check_all();
    check_ports(active, 3'b001, "wait test grant");
    next_cycle();
    drop_port(1);
    set_port(2, 1'b1, NONSEQ, SINGLE, 1'b0);  // New requests during stall
    set_port(3, 1'b1, NONSEQ, SINGLE, 1'b0);
    hreadyout = 1'b0;
    check_all();
    check_flag(hreadymux, 1'b0, "stall follows slave");
    check_ports(active, 3'b000, "no owner at stall start");
    check_word(hwdata, wd, "stalled write data");
    for (int k = 1; k < n; k++)
    begin
      next_cycle();
      set_port(2, 1'b1, NONSEQ, SINGLE, 1'b0);
      set_port(3, 1'b1, NONSEQ, SINGLE, 1'b0);
      check_all();
      check_flag(hreadymux, 1'b0, "stall held");
      check_ports(active, 3'b000, "active frozen");
      check_word(hwdata, wd, "write data frozen");
    end
    next_cycle();
    hreadyout = 1'b1;
    check_all();
    check_flag(hreadymux, 1'b1, "stall released");
    check_ports(active, 3'b000, "active frozen at release");
    check_word(hwdata, wd, "write data frozen at release");
    next_cycle();
    check_all();
    check_ports(active, 3'b010, "arbitration resumes");
  endtask

  // --------------------------------------
  // Main sequence
  // --------------------------------------
  initial
  begin
    rng_state   = 32'd52748;
    cycle_count = 0;
    HRESETn     = 1'b0;
    idle_inputs();
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
      wdata[p] = '0;
    m_grant = NO_PORT;
    m_last  = port_idx_t'(`MTX_NUM_PORTS);  // Port 1 wins first
    m_lock  = 1'b0;
    m_dport = NO_PORT;
    m_ssel  = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    HRESETn = 1'b1;
    test_reset();
    test_single();
    idle_cycles(3);
    test_round_robin();
    idle_cycles(3);
    test_burst_hold();
    idle_cycles(3);
    test_locked();
    idle_cycles(3);
    test_wait_states();
    idle_cycles(3);
    $display("Verification passed");
    $finish;
  end

endmodule
